// ==== bench/noc_chain_cases.txt ====
# name I dst op data_hex | name B | name C tile count sum_hex max_hex | name S count dst
# op is ADD, CLEAR or NOP; count, tile and dst are decimal
reset_t0 C 0 0 0000 0000
reset_t1 C 1 0 0000 0000
reset_t2 C 2 0 0000 0000
reset_t3 C 3 0 0000 0000
reset_stray S 0 0
add_each I 0 ADD 0010
add_each I 0 ADD 0030
add_each I 0 ADD 0020
add_each I 1 ADD 1234
add_each I 2 ADD 00ff
add_each I 2 ADD 0100
add_each I 3 ADD 8000
add_each I 3 ADD 0001
add_t0 C 0 3 0060 0030
add_t1 C 1 1 1234 1234
add_t2 C 2 2 01ff 0100
add_t3 C 3 2 8001 8000
add_stray S 0 0
clear_t2 I 2 CLEAR abcd
clear_t2 C 2 0 0000 0000
clear_keep_t0 C 0 3 0060 0030
clear_keep_t1 C 1 1 1234 1234
clear_keep_t3 C 3 2 8001 8000
nop_t2 I 2 NOP 5555
nop_t2 C 2 1 0000 0000
stray_pass I 4 ADD 0001
stray_pass I 7 ADD 0002
stray_pass I 5 NOP 0003
stray_pass I 6 CLEAR 0004
stray_keep_t0 C 0 3 0060 0030
stray_keep_t1 C 1 1 1234 1234
stray_keep_t2 C 2 1 0000 0000
stray_keep_t3 C 3 2 8001 8000
stray_record S 4 6
burst_mix I 0 ADD 0001
burst_mix I 1 ADD 0002
burst_mix I 5 ADD 0003
burst_mix I 1 ADD 0004
burst_mix I 3 NOP 0005
burst_mix I 2 ADD 0006
burst_mix I 0 ADD 0007
burst_mix I 4 ADD 0008
burst_mix B
burst_t0 C 0 5 0068 0030
burst_t1 C 1 3 123a 1234
burst_t2 C 2 2 0006 0006
burst_t3 C 3 3 8001 8000
burst_stray S 6 4
wrap_sum I 3 CLEAR 0000
wrap_sum I 3 ADD ff00
wrap_sum I 3 ADD 0300
wrap_sum B
wrap_t3 C 3 2 0200 ff00
wrap_keep_t1 C 1 3 123a 1234
wrap_stray S 6 4

// ==== vlog.f ====
source/noc_pkg.sv
source/noc_injector.sv
source/noc_router.sv
source/noc_tile_sink.sv
source/noc_tile.sv
source/noc_edge_terminator.sv
source/noc_chain_top.sv
bench/noc_chain_tb.sv

// ==== bench/noc_chain_tb.sv ====
// Testbench for the flit chain network
// Replays the cases file against the chain, injecting commands and
// checking tile statistics and the stray record at the east edge
`timescale 1ns/1ps
`default_nettype none

module noc_chain_tb;

  localparam int unsigned ClkHalf       = 4;    // 8 ns period
  localparam int unsigned ResetCycles   = 3;
  localparam int unsigned CyclesPerLine = 20;
  localparam int unsigned SettleCycles  = noc_pkg::NumTiles + 3;
  localparam int unsigned Seed          = 32'h1bf5_1f67;
  localparam CasesPath = "bench/noc_chain_cases.txt";

  logic                                        clk;
  logic                                        rst_n;
  logic                                        inj_valid;
  logic                [noc_pkg::IdWidth-1:0]   inj_dst;
  noc_pkg::op_e                                inj_op;
  logic                [noc_pkg::DataWidth-1:0] inj_data;
  noc_pkg::tile_stat_t [noc_pkg::NumTiles-1:0]  stats;
  noc_pkg::stray_t                             stray;

  string          lines[$];     // Raw lines of the cases file
  noc_pkg::flit_t pending[$];   // Flits waiting for the next burst or check
  noc_pkg::flit_t last_stray  = '0;   // Latest flit sent beyond the chain
  int unsigned    num_lines   = 0;
  bit             lines_ready = 1'b0;

  noc_chain_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .inj_valid_i (inj_valid),
    .inj_dst_i   (inj_dst),
    .inj_op_i    (inj_op),
    .inj_data_i  (inj_data),
    .stats_o     (stats),
    .stray_o     (stray)
  );

  initial begin
    clk = 1'b0;
    forever #ClkHalf clk = ~clk;
  end

  // Budget grows with the number of lines in the file
  initial begin : watchdog
    wait (lines_ready);
    repeat (CyclesPerLine * num_lines + ResetCycles + 2) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles for %0d lines",
             CyclesPerLine * num_lines, num_lines);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string case_name, input string field,
                             input int unsigned expected, input int unsigned actual);
    assert (actual == expected) else begin
      fail_now($sformatf("Mismatch case %s %s expected 0x%0h actual 0x%0h",
                         case_name, field, expected, actual));
    end
  endtask

  task automatic parse_op(input string case_name, input string name,
                          output noc_pkg::op_e op);
    op = noc_pkg::OP_NOP;
    if (name == "ADD") begin
      op = noc_pkg::OP_ADD;
    end else if (name == "CLEAR") begin
      op = noc_pkg::OP_CLEAR;
    end else if (name == "NOP") begin
      op = noc_pkg::OP_NOP;
    end else begin
      fail_now($sformatf("Case %s uses an unknown opcode %s", case_name, name));
    end
  endtask

  // Drains the pending queue, with random idle gaps unless a burst
  task automatic send_pending(input bit back_to_back);
    noc_pkg::flit_t f;
    int unsigned    gap;
    while (pending.size() > 0) begin
      f = pending.pop_front();
      if (f.dst >= noc_pkg::NumTiles) begin
        last_stray = f;   // Terminator keeps the latest of these
      end
      if (!back_to_back) begin
        gap       = $urandom_range(3, 0);
        inj_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      inj_valid = 1'b1;
      inj_dst   = f.dst;
      inj_op    = f.op;
      inj_data  = f.payload;
      @(negedge clk);
    end
    inj_valid = 1'b0;
  endtask

  task automatic settle();
    send_pending(1'b0);
    repeat (SettleCycles) @(negedge clk);   // Every flit has left the chain
  endtask

  task automatic check_tile(input string case_name, input int unsigned tile,
                            input int unsigned count, input int unsigned sum,
                            input int unsigned max);
    noc_pkg::tile_stat_t st;
    assert (tile < noc_pkg::NumTiles) else begin
      fail_now($sformatf("Case %s checks tile %0d, which is not in the chain",
                         case_name, tile));
    end
    settle();
    st = stats[tile];
    check_value(case_name, $sformatf("tile %0d count", tile), count, st.count);
    check_value(case_name, $sformatf("tile %0d sum", tile), sum, st.sum);
    check_value(case_name, $sformatf("tile %0d max", tile), max, st.max);
  endtask

  task automatic check_stray(input string case_name, input int unsigned count,
                             input int unsigned dst);
    settle();
    check_value(case_name, "stray count", count, stray.count);
    check_value(case_name, "stray last dst", dst, stray.last.dst);
    check_value(case_name, "stray last valid", last_stray.valid, stray.last.valid);
    check_value(case_name, "stray last op", last_stray.op, stray.last.op);
    check_value(case_name, "stray last payload", last_stray.payload,
                stray.last.payload);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int             fd;
    int             code;
    string          line;
    string          case_name;
    string          kind;
    string          op_name;
    int unsigned    a0;
    int unsigned    a1;
    int unsigned    a2;
    int unsigned    a3;
    noc_pkg::op_e   op;
    noc_pkg::flit_t f;

    rst_n     = 1'b0;
    inj_valid = 1'b0;
    inj_dst   = '0;
    inj_op    = noc_pkg::OP_NOP;
    inj_data  = '0;
    void'($urandom(Seed));

    fd = $fopen(CasesPath, "r");
    if (fd == 0) begin
      fail_now($sformatf("Cannot open the cases file %s", CasesPath));
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0) begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    num_lines   = lines.size();
    lines_ready = 1'b1;

    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (lines[i]) begin
      line = lines[i];
      // Blank lines and lines starting with # carry no command
      if ($sscanf(line, "%s %s", case_name, kind) == 2 && case_name.getc(0) != "#") begin
        if (kind == "I") begin
          code = $sscanf(line, "%s %s %d %s %h", case_name, kind, a0, op_name, a1);
          assert (code == 5) else fail_now($sformatf("Malformed inject line: %s", line));
          parse_op(case_name, op_name, op);
          f.valid   = 1'b1;
          f.dst     = a0[noc_pkg::IdWidth-1:0];
          f.op      = op;
          f.payload = a1[noc_pkg::DataWidth-1:0];
          pending.push_back(f);
        end else if (kind == "B") begin
          send_pending(1'b1);
        end else if (kind == "C") begin
          code = $sscanf(line, "%s %s %d %d %h %h", case_name, kind, a0, a1, a2, a3);
          assert (code == 6) else fail_now($sformatf("Malformed tile check: %s", line));
          check_tile(case_name, a0, a1, a2, a3);
        end else if (kind == "S") begin
          code = $sscanf(line, "%s %s %d %d", case_name, kind, a0, a1);
          assert (code == 4) else fail_now($sformatf("Malformed stray check: %s", line));
          check_stray(case_name, a0, a1);
        end else begin
          fail_now($sformatf("Case %s has an unknown kind %s", case_name, kind));
        end
      end
    end

    settle();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/noc_chain_top.sv ====
// Flit chain top level
// Injector at the west edge, NumTiles dummy tiles in a row and a
// terminator for destinations beyond the last tile
`timescale 1ns/1ps
`default_nettype none

module noc_chain_top (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         inj_valid_i,
  input  logic                [noc_pkg::IdWidth-1:0]   inj_dst_i,
  input  noc_pkg::op_e                                 inj_op_i,
  input  logic                [noc_pkg::DataWidth-1:0] inj_data_i,
  output noc_pkg::tile_stat_t [noc_pkg::NumTiles-1:0]  stats_o,
  output noc_pkg::stray_t                              stray_o
);

  // Hop k feeds tile k, the last hop feeds the terminator
  noc_pkg::flit_t [noc_pkg::NumTiles:0] link;

  ////////////////////////////////////////////////////////////
  // West edge
  ////////////////////////////////////////////////////////////

  noc_injector u_injector (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .inj_valid_i (inj_valid_i),
    .inj_dst_i   (inj_dst_i),
    .inj_op_i    (inj_op_i),
    .inj_data_i  (inj_data_i),
    .flit_o      (link[0])
  );

  ////////////////////////////////////////////////////////////
  // Tile chain
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < noc_pkg::NumTiles; k++) begin : g_tile
    noc_tile #(
      .TileId (k)
    ) u_tile (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .west_i  (link[k]),
      .east_o  (link[k+1]),
      .stat_o  (stats_o[k])
    );
  end

  ////////////////////////////////////////////////////////////
  // East edge
  ////////////////////////////////////////////////////////////

  noc_edge_terminator u_terminator (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .east_i  (link[noc_pkg::NumTiles]),
    .stray_o (stray_o)
  );

endmodule

`default_nettype wire

// ==== source/noc_edge_terminator.sv ====
// East edge terminator
// Drains flits that passed every tile and records them as stray
`timescale 1ns/1ps
`default_nettype none

module noc_edge_terminator (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  noc_pkg::flit_t  east_i,
  output noc_pkg::stray_t stray_o
);

  logic [7:0]     count_q;
  noc_pkg::flit_t last_q;

  ////////////////////////////////////////////////////////////
  // Stray record
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= 8'd0;
      last_q  <= '0;
    end else if (east_i.valid) begin
      count_q <= count_q + 8'd1;   // Wraps after 255
      last_q  <= east_i;
    end
  end

  always_comb begin
    stray_o.count = count_q;
    stray_o.last  = last_q;
  end

endmodule

`default_nettype wire

// ==== source/noc_tile.sv ====
// Dummy network tile
// One router on the east-west chain, local traffic ends in the sink
// and never leaves the tile
`timescale 1ns/1ps
`default_nettype none

module noc_tile #(
  parameter int unsigned TileId = 0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::flit_t      west_i,
  output noc_pkg::flit_t      east_o,
  output noc_pkg::tile_stat_t stat_o
);

  ////////////////////////////////////////////////////////////
  // Router
  ////////////////////////////////////////////////////////////

  noc_pkg::flit_t eject;   // Flits addressed to this tile

  noc_router #(
    .TileId (TileId)
  ) u_router (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .west_i  (west_i),
    .east_o  (east_o),
    .eject_o (eject)
  );

  ////////////////////////////////////////////////////////////
  // Local sink
  ////////////////////////////////////////////////////////////

  // Nothing is injected locally, the tile only absorbs
  noc_tile_sink u_sink (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .eject_i (eject),
    .stat_o  (stat_o)
  );

endmodule

`default_nettype wire

// ==== source/noc_tile_sink.sv ====
// Tile statistics sink
// Consumes ejected flits and keeps count, wrapped sum and maximum
`timescale 1ns/1ps
`default_nettype none

module noc_tile_sink (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::flit_t      eject_i,
  output noc_pkg::tile_stat_t stat_o
);

  noc_pkg::tile_stat_t stat_q;
  noc_pkg::tile_stat_t stat_d;

  ////////////////////////////////////////////////////////////
  // Opcode handling
  ////////////////////////////////////////////////////////////

  always_comb begin
    stat_d = stat_q;
    if (eject_i.valid) begin
      case (eject_i.op)
        noc_pkg::OP_CLEAR: begin
          stat_d = '0;
        end
        noc_pkg::OP_ADD: begin
          stat_d.count = stat_q.count + 8'd1;
          stat_d.sum   = stat_q.sum + eject_i.payload;   // Wraps at 16 bits
          if (eject_i.payload > stat_q.max) begin
            stat_d.max = eject_i.payload;
          end
        end
        noc_pkg::OP_NOP: begin
          stat_d.count = stat_q.count + 8'd1;
        end
        default: begin
          // Unused opcode leaves the record alone
          stat_d = stat_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_q <= '0;
    end else begin
      stat_q <= stat_d;
    end
  end

  assign stat_o = stat_q;

endmodule

`default_nettype wire

// ==== source/noc_router.sv ====
// Single channel tile router
// Ejects flits whose destination matches this tile, and forwards
// all others east through one register stage
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter int unsigned TileId = 0
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  noc_pkg::flit_t west_i,
  output noc_pkg::flit_t east_o,
  output noc_pkg::flit_t eject_o
);

  ////////////////////////////////////////////////////////////
  // Route decision
  ////////////////////////////////////////////////////////////

  logic hit;   // Destination is this tile
  logic fwd;   // Valid flit heading further east

  assign hit = (west_i.dst == TileId[noc_pkg::IdWidth-1:0]);
  assign fwd = west_i.valid && !hit;

  // Local port, same cycle as the west input
  always_comb begin
    eject_o       = west_i;
    eject_o.valid = west_i.valid && hit;
  end

  ////////////////////////////////////////////////////////////
  // East output stage
  ////////////////////////////////////////////////////////////

  logic           east_valid_q;
  noc_pkg::flit_t east_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      east_valid_q <= 1'b0;
    end else begin
      east_valid_q <= fwd;   // Ejected or idle input leaves east idle
    end
  end

  // Flit body follows the strobe
  always_ff @(posedge clk_i) begin
    if (fwd) begin
      east_q <= west_i;
    end
  end

  always_comb begin
    east_o       = east_q;
    east_o.valid = east_valid_q;
  end

endmodule

`default_nettype wire

// ==== source/noc_injector.sv ====
// West edge injector
// Registers a host command strobe into the first flit of the chain
`timescale 1ns/1ps
`default_nettype none

module noc_injector (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          inj_valid_i,
  input  logic [noc_pkg::IdWidth-1:0]   inj_dst_i,
  input  noc_pkg::op_e                  inj_op_i,
  input  logic [noc_pkg::DataWidth-1:0] inj_data_i,
  output noc_pkg::flit_t                flit_o
);

  logic                          valid_q;
  logic [noc_pkg::IdWidth-1:0]   dst_q;
  noc_pkg::op_e                  op_q;
  logic [noc_pkg::DataWidth-1:0] data_q;

  // Strobe is cleared whenever no command is offered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= inj_valid_i;
    end
  end

  // Command fields, only loaded with a strobe
  always_ff @(posedge clk_i) begin
    if (inj_valid_i) begin
      dst_q  <= inj_dst_i;
      op_q   <= inj_op_i;
      data_q <= inj_data_i;
    end
  end

  always_comb begin
    flit_o.valid   = valid_q;
    flit_o.dst     = dst_q;
    flit_o.op      = op_q;
    flit_o.payload = data_q;
  end

endmodule

`default_nettype wire

// ==== source/noc_pkg.sv ====
// Shared types and constants of the flit chain network
// Flit format, opcodes and the statistics records of tiles and edge
`default_nettype none

package noc_pkg;

  ////////////////////////////////////////////////////////////
  // Network dimensions
  ////////////////////////////////////////////////////////////

  localparam int unsigned NumTiles  = 4;
  localparam int unsigned IdWidth   = 3;   // Ids above NumTiles-1 end up stray
  localparam int unsigned DataWidth = 16;

  ////////////////////////////////////////////////////////////
  // Flit
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD   = 2'd0,  // Fold payload into the statistics
    OP_CLEAR = 2'd1,  // Zero the statistics
    OP_NOP   = 2'd2   // Counted only
  } op_e;

  typedef struct packed {
    logic                 valid;
    logic [IdWidth-1:0]   dst;
    op_e                  op;
    logic [DataWidth-1:0] payload;
  } flit_t;

  ////////////////////////////////////////////////////////////
  // Statistics records
  ////////////////////////////////////////////////////////////

  // Per tile, all fields wrap except max
  typedef struct packed {
    logic [7:0]           count;
    logic [DataWidth-1:0] sum;
    logic [DataWidth-1:0] max;   // Unsigned maximum of added payloads
  } tile_stat_t;

  // Flits that ran off the east edge
  typedef struct packed {
    logic [7:0] count;
    flit_t      last;
  } stray_t;

endpackage

`default_nettype wire
